/* src.f */
+incdir+src
src/fpu_slice_pkg.sv
src/fpu_slice_ifs.sv
src/slice_issue.sv
src/minmax_core.sv
src/lane_pipe.sv
src/slice_pack.sv
src/fpu_slice_top.sv
testbench/tb_clkgen.sv
testbench/tb_checker.sv
testbench/tb_fpu_slice.sv

/* testbench/slice_vectors.txt */
// Columns: op_fmt_vec_mask_operandA_operandB_expResult_expStatus, hex
// op 0 min 1 max, fmt 0 FP32 1 FP16, status 10 is NV
0_0_0_3_3F800000_40000000_3F800000_00
1_0_0_3_3F800000_40000000_40000000_00
0_0_0_3_BF800000_40000000_BF800000_00
1_0_0_3_C0400000_BF800000_BF800000_00
0_0_0_3_80000000_00000000_80000000_00
1_0_0_3_80000000_00000000_00000000_00
0_0_0_3_7FC00000_40A00000_40A00000_00
1_0_0_3_3FC00000_7FC12345_3FC00000_00
0_0_0_3_7FC00000_7FC00000_7FC00000_00
1_0_0_3_7F800001_40400000_40400000_10
0_0_0_3_7FA00000_7FC00000_7FC00000_10
1_0_0_0_FF800005_3F800000_3F800000_00
0_1_0_3_FFFF3C00_FFFF4000_FFFF3C00_00
1_1_0_3_FFFFBC00_FFFF8000_FFFF8000_00
1_1_0_3_00003C00_FFFF4000_FFFF4000_00
0_1_0_3_12343C00_FFFF7E01_FFFF7E00_00
0_1_0_3_FFFF7C01_FFFF3800_FFFF3800_10
0_1_1_3_40003C00_38004000_38003C00_00
1_1_1_3_7C01BC00_40000000_40000000_10
1_1_1_1_7C01BC00_40000000_40000000_00
0_1_1_2_7E007C01_7E00C000_7E00C000_00
1_1_1_3_FFFF0000_3C003C00_3C003C00_00

/* testbench/tb_fpu_slice.sv */
// Testbench top of the FPU slice
// Replays the vectors file twice, first with the output always ready and
// latency checked, then under random back-pressure, and ends with a flush

`timescale 1ns/1ps

module tb_fpu_slice;
  import fpu_slice_pkg::*;

  localparam int MAX_VECS = 64;
  localparam int TIMEOUT  = 200;  // Cycles allowed per wait

  logic         clk_i;
  logic         reset_i;
  word_t        operand_a;
  word_t        operand_b;
  minmax_op_e   op;
  fp_fmt_e      fmt;
  logic         vectorial;
  lane_mask_t   simd_mask;
  tag_t         tag;
  logic         in_valid;
  logic         in_ready;
  logic         flush;
  logic         out_ready;
  word_t        result;
  status_t      status;
  tag_t         out_tag;
  logic         out_valid;
  logic         busy;
  word_t        exp_result;
  status_t      exp_status;
  logic         lat_check;
  int           error_count;
  int           pending;
  int           num_vecs;
  int           failures;
  logic [1:0]   ready_mode;  // 0 always ready, 1 random, 2 stalled
  logic [31:0]  rnd_state;
  logic [119:0] vectors [MAX_VECS];

  tb_clkgen u_clkgen (.clk_o(clk_i));

  fpu_slice_top DUT (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .operand_a_i    (operand_a),
    .operand_b_i    (operand_b),
    .op_i           (op),
    .fmt_i          (fmt),
    .vectorial_op_i (vectorial),
    .simd_mask_i    (simd_mask),
    .tag_i          (tag),
    .in_valid_i     (in_valid),
    .in_ready_o     (in_ready),
    .flush_i        (flush),
    .result_o       (result),
    .status_o       (status),
    .tag_o          (out_tag),
    .out_valid_o    (out_valid),
    .out_ready_i    (out_ready),
    .busy_o         (busy)
  );

  tb_checker u_checker (
    .clk_i         (clk_i),
    .in_valid_i    (in_valid),
    .in_ready_i    (in_ready),
    .tag_i         (tag),
    .exp_result_i  (exp_result),
    .exp_status_i  (exp_status),
    .out_valid_i   (out_valid),
    .out_ready_i   (out_ready),
    .result_i      (result),
    .status_i      (status),
    .out_tag_i     (out_tag),
    .busy_i        (busy),
    .flush_i       (flush),
    .lat_check_i   (lat_check),
    .error_count_o (error_count),
    .pending_o     (pending)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Output back-pressure, updated every cycle
  always @(posedge clk_i) begin : drive_ready
    #1;
    rnd_state = xorshift32(rnd_state);
    case (ready_mode)
      2'd0:    out_ready = 1'b1;
      2'd1:    out_ready = |rnd_state[1:0];  // Ready about 3 cycles in 4
      default: out_ready = 1'b0;
    endcase
  end

  // --------------------
  // Stimulus tasks
  // --------------------
  // Returns on the falling edge before the transfer edge
  task automatic send_request(input int idx);
    logic [119:0] v;
    int           waited;
    v = vectors[idx];
    @(posedge clk_i);
    #1;
    op         = minmax_op_e'(v[116]);
    fmt        = fp_fmt_e'(v[112]);
    vectorial  = v[108];
    simd_mask  = v[105:104];
    operand_a  = v[103:72];
    operand_b  = v[71:40];
    exp_result = v[39:8];
    exp_status = v[4:0];
    tag        = tag_t'(idx);  // Line number of the vector
    in_valid   = 1'b1;
    waited     = 0;
    @(negedge clk_i);
    while (!in_ready && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!in_ready) begin
      failures++;
      $display("timeout: in_ready_o stayed low for vector %0d", idx);
    end
  endtask

  task automatic end_requests();
    @(posedge clk_i);
    #1;
    in_valid = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic run_vectors();
    for (int i = 0; i < num_vecs; i++) begin
      send_request(i);
    end
    end_requests();
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk_i);
    #1;
    while ((busy || pending != 0) && waited < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (busy || pending != 0) begin
      failures++;
      $display("timeout: %0d results still outstanding", pending);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin : main
    reset_i    = 1'b1;
    operand_a  = '0;
    operand_b  = '0;
    op         = OP_MIN;
    fmt        = FMT_FP32;
    vectorial  = 1'b0;
    simd_mask  = '0;
    tag        = '0;
    in_valid   = 1'b0;
    flush      = 1'b0;
    out_ready  = 1'b1;
    exp_result = '0;
    exp_status = '0;
    lat_check  = 1'b1;
    ready_mode = 2'd0;
    rnd_state  = 32'd24924;
    failures   = 0;

    for (int i = 0; i < MAX_VECS; i++) begin
      vectors[i] = '1;  // Op digit above 1 marks the end
    end
    $readmemh("testbench/slice_vectors.txt", vectors);
    num_vecs = 0;
    while (num_vecs < MAX_VECS && vectors[num_vecs][119:116] <= 4'h1) begin
      num_vecs++;
    end
    if (num_vecs < 4) begin
      failures++;
      $display("too few vectors read from testbench/slice_vectors.txt: %0d", num_vecs);
    end

    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);

    run_vectors();  // Always ready, fixed latency
    drain();

    lat_check  = 1'b0;
    ready_mode = 2'd1;
    run_vectors();
    drain();

    // Stall two requests in the pipes, then flush them away
    ready_mode = 2'd2;
    send_request(0);
    send_request(1);
    @(posedge clk_i);
    #1;
    in_valid = 1'b0;
    flush    = 1'b1;
    @(posedge clk_i);
    #1;
    flush = 1'b0;
    @(negedge clk_i);
    ready_mode = 2'd0;
    send_request(2);
    send_request(3);
    end_requests();
    drain();

    u_checker.print_summary(failures);
    if (error_count == 0 && failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* testbench/tb_checker.sv */
// Scoreboard of the FPU slice testbench
// Queues the expected result of every accepted request and compares in order.
// Samples on the falling edge, where the DUT ports are settled

`timescale 1ns/1ps
`include "fpu_slice_consts.svh"

module tb_checker (
  input  logic                   clk_i,
  input  logic                   in_valid_i,
  input  logic                   in_ready_i,
  input  fpu_slice_pkg::tag_t    tag_i,
  input  fpu_slice_pkg::word_t   exp_result_i,
  input  fpu_slice_pkg::status_t exp_status_i,
  input  logic                   out_valid_i,
  input  logic                   out_ready_i,
  input  fpu_slice_pkg::word_t   result_i,
  input  fpu_slice_pkg::status_t status_i,
  input  fpu_slice_pkg::tag_t    out_tag_i,
  input  logic                   busy_i,
  input  logic                   flush_i,
  input  logic                   lat_check_i,
  output int                     error_count_o,
  output int                     pending_o
);
  import fpu_slice_pkg::*;

  typedef struct packed {
    word_t       result;
    status_t     status;
    tag_t        tag;
    logic [31:0] cycle;  // Acceptance cycle
  } expect_t;

  expect_t expect_q[$];
  int      mismatches = 0;
  int      others     = 0;
  int      cycle      = 0;
  logic    flush_seen = 1'b0;

  initial begin
    error_count_o = 0;
    pending_o     = 0;
  end

  always @(negedge clk_i) begin : compare
    expect_t exp;
    int      latency;
    logic    exp_ready;
    cycle++;
    if (flush_i) begin
      expect_q.delete();  // In-flight requests are dropped
      flush_seen = 1'b1;
    end else begin
      if (flush_seen) begin
        if (busy_i || out_valid_i) begin
          others++;
          $display("busy_o or out_valid_o still high in the cycle after flush");
        end
        flush_seen = 1'b0;
      end
      // Lane 0 holds every request, so its stages fill up first
      exp_ready = (expect_q.size() < `NUM_PIPE_REGS) || out_ready_i;
      if (in_ready_i !== exp_ready) begin
        mismatches++;
        $display("mismatch in_ready_o: got %h expected %h", in_ready_i, exp_ready);
      end
      // --------------------
      // Output side
      // --------------------
      if (out_valid_i && out_ready_i) begin
        if (expect_q.size() == 0) begin
          others++;
          $display("result with tag %h came out with no request pending", out_tag_i);
        end else begin
          exp     = expect_q.pop_front();
          latency = cycle - int'(exp.cycle);
          if (result_i !== exp.result) begin
            mismatches++;
            $display("mismatch result: got %h expected %h (tag %h)",
                     result_i, exp.result, exp.tag);
          end
          if (status_i !== exp.status) begin
            mismatches++;
            $display("mismatch status: got %h expected %h (tag %h)",
                     status_i, exp.status, exp.tag);
          end
          if (out_tag_i !== exp.tag) begin
            mismatches++;
            $display("mismatch tag: got %h expected %h", out_tag_i, exp.tag);
          end
          if (lat_check_i && latency != `NUM_PIPE_REGS) begin
            others++;
            $display("tag %h took %0d cycles instead of %0d", exp.tag, latency,
                     `NUM_PIPE_REGS);
          end
        end
      end
      if (in_valid_i && in_ready_i) begin  // Transfer on the next rising edge
        exp.result = exp_result_i;
        exp.status = exp_status_i;
        exp.tag    = tag_i;
        exp.cycle  = cycle;
        expect_q.push_back(exp);
      end
    end
    pending_o     = expect_q.size();
    error_count_o = mismatches + others;
  end

  task automatic print_summary(input int failures);
    $display("errors: %0d mismatches, %0d other, %0d testbench failures",
             mismatches, others, failures);
  endtask

endmodule

/* testbench/tb_clkgen.sv */
// Free-running testbench clock, 8 ns period unless overridden

`timescale 1ns/1ps

module tb_clkgen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk_o
);
  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;  // First rising edge at half a period

endmodule

/* src/fpu_slice_top.sv */
// Top level of the two-lane min/max FPU slice
// Issue feeds one min/max core and one register pipe per lane,
// packing merges the lanes back into one result word

`timescale 1ns/1ps
`include "fpu_slice_consts.svh"

module fpu_slice_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  fpu_slice_pkg::word_t      operand_a_i,
  input  fpu_slice_pkg::word_t      operand_b_i,
  input  fpu_slice_pkg::minmax_op_e op_i,
  input  fpu_slice_pkg::fp_fmt_e    fmt_i,
  input  logic                      vectorial_op_i,
  input  fpu_slice_pkg::lane_mask_t simd_mask_i,
  input  fpu_slice_pkg::tag_t       tag_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic                      flush_i,
  output fpu_slice_pkg::word_t      result_o,
  output fpu_slice_pkg::status_t    status_o,
  output fpu_slice_pkg::tag_t       tag_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic                      busy_o
);
  import fpu_slice_pkg::*;

  lane_req_if req_if [`NUM_LANES] (.clk_i(clk_i));
  lane_rsp_if rsp_if [`NUM_LANES] (.clk_i(clk_i));

  logic [`NUM_LANES-1:0] lane_busy;

  slice_issue u_issue (
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .op_i           (op_i),
    .fmt_i          (fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .simd_mask_i    (simd_mask_i),
    .tag_i          (tag_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .lane0_o        (req_if[0]),
    .lane1_o        (req_if[1])
  );

  // --------------------
  // Lanes
  // --------------------
  for (genvar i = 0; i < `NUM_LANES; i++) begin : gen_lanes
    word_t   core_result;
    status_t core_status;

    minmax_core u_core (
      .operand_a_i (req_if[i].operand_a),
      .operand_b_i (req_if[i].operand_b),
      .fmt_i       (req_if[i].fmt),
      .op_i        (req_if[i].op),
      .result_o    (core_result),
      .status_o    (core_status)
    );

    lane_pipe u_pipe (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .result_i (core_result),
      .status_i (core_status),
      .req_i    (req_if[i]),
      .rsp_o    (rsp_if[i]),
      .flush_i  (flush_i),
      .busy_o   (lane_busy[i])
    );
  end

  slice_pack u_pack (
    .lane0_i     (rsp_if[0]),
    .lane1_i     (rsp_if[1]),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o)
  );

  assign busy_o = |lane_busy;  // Data in flight in any lane

endmodule

/* src/slice_pack.sv */
// Output side of the FPU slice
// Packs lane results into one word with NaN-boxing, collapses the
// status under the SIMD mask and hands ready back to the lanes

`timescale 1ns/1ps

module slice_pack (
  lane_rsp_if.pack               lane0_i,
  lane_rsp_if.pack               lane1_i,
  input  logic                   out_ready_i,
  output fpu_slice_pkg::word_t   result_o,
  output fpu_slice_pkg::status_t status_o,
  output fpu_slice_pkg::tag_t    tag_o,
  output logic                   out_valid_o
);
  import fpu_slice_pkg::*;

  logic    res_fp16;
  logic    res_vector;
  logic    hi_used;    // Lane 1 contributes to this result
  half_t   hi_half;
  status_t lane0_status;
  status_t lane1_status;

  // Lane 0 aux decides the layout
  assign res_fp16   = lane0_i.aux[AUX_FMT];
  assign res_vector = lane0_i.aux[AUX_VEC];
  assign hi_used    = res_vector & lane1_i.valid;

  assign lane0_i.ready = out_ready_i;
  assign lane1_i.ready = out_ready_i & res_vector;  // Both lanes pop together

  // --------------------
  // Result and status
  // --------------------
  assign hi_half  = hi_used ? lane1_i.result[15:0] : 16'hFFFF;  // NaN-box otherwise
  assign result_o = res_fp16 ? {hi_half, lane0_i.result[15:0]} : lane0_i.result;

  assign lane0_status = lane0_i.mask ? lane0_i.status : '0;
  assign lane1_status = (hi_used && lane1_i.mask) ? lane1_i.status : '0;
  assign status_o     = lane0_status | lane1_status;

  assign tag_o       = lane0_i.tag;
  assign out_valid_o = lane0_i.valid;

  // A vector result finds its partner at the head of lane 1
  lane_pair_a: assert property (@(posedge lane0_i.clk_i)
    lane0_i.valid && res_vector |->
      lane1_i.valid && (lane1_i.tag == lane0_i.tag) && (lane1_i.aux == lane0_i.aux));

endmodule

/* src/lane_pipe.sv */
// Valid/ready register pipeline of one lane
// Carries result, status, mask, tag and aux through NUM_PIPE_REGS stages.
// A stage loads when empty or when its successor moves; flush drops all

`timescale 1ns/1ps
`include "fpu_slice_consts.svh"

module lane_pipe (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  fpu_slice_pkg::word_t   result_i,
  input  fpu_slice_pkg::status_t status_i,
  lane_req_if.lane               req_i,
  lane_rsp_if.lane               rsp_o,
  input  logic                   flush_i,
  output logic                   busy_o
);
  import fpu_slice_pkg::*;

  localparam int unsigned NREG = `NUM_PIPE_REGS;

  typedef struct packed {
    word_t   result;
    status_t status;
    logic    mask;
    tag_t    tag;
    aux_t    aux;
  } entry_t;

  logic   [NREG-1:0] valid_q;
  entry_t [NREG-1:0] data_q;
  logic   [NREG-1:0] feed_valid;   // What stage i would load
  entry_t [NREG-1:0] feed_data;
  logic   [NREG-1:0] stage_ready;  // Stage i may load this cycle

  // --------------------
  // Stage inputs
  // --------------------
  always_comb begin : feed
    feed_valid[0]       = req_i.valid;
    feed_data[0].result = result_i;
    feed_data[0].status = status_i;
    feed_data[0].mask   = req_i.mask;
    feed_data[0].tag    = req_i.tag;
    feed_data[0].aux    = req_i.aux;
    for (int i = 1; i < NREG; i++) begin
      feed_valid[i] = valid_q[i-1];
      feed_data[i]  = data_q[i-1];
    end
  end

  // Ready travels back from the packing side
  always_comb begin : ready_chain
    stage_ready[NREG-1] = ~valid_q[NREG-1] | rsp_o.ready;
    for (int i = NREG - 2; i >= 0; i--) begin
      stage_ready[i] = ~valid_q[i] | stage_ready[i+1];
    end
  end

  always_ff @(posedge clk_i) begin : valid_regs
    if (reset_i || flush_i) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < NREG; i++) begin
        if (stage_ready[i]) valid_q[i] <= feed_valid[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin : data_regs
    for (int i = 0; i < NREG; i++) begin
      if (stage_ready[i] && feed_valid[i]) data_q[i] <= feed_data[i];
    end
  end

  // --------------------
  // Outputs
  // --------------------
  assign req_i.ready  = stage_ready[0];
  assign rsp_o.valid  = valid_q[NREG-1];
  assign rsp_o.result = data_q[NREG-1].result;
  assign rsp_o.status = data_q[NREG-1].status;
  assign rsp_o.mask   = data_q[NREG-1].mask;
  assign rsp_o.tag    = data_q[NREG-1].tag;
  assign rsp_o.aux    = data_q[NREG-1].aux;
  assign busy_o       = |valid_q;

  // A stalled result stays put until the packing side takes it
  hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_o.valid && !rsp_o.ready && !flush_i |=> rsp_o.valid && $stable(data_q[NREG-1]));

endmodule

/* src/minmax_core.sv */
// IEEE min/max of one lane with RISC-V fmin/fmax NaN rules
// Works on FP32 words or on FP16 values in bits 15:0
// Combinational, status carries NV only

`timescale 1ns/1ps
`include "fpu_slice_consts.svh"

module minmax_core (
  input  fpu_slice_pkg::word_t      operand_a_i,
  input  fpu_slice_pkg::word_t      operand_b_i,
  input  fpu_slice_pkg::fp_fmt_e    fmt_i,
  input  fpu_slice_pkg::minmax_op_e op_i,
  output fpu_slice_pkg::word_t      result_o,
  output fpu_slice_pkg::status_t    status_o
);
  import fpu_slice_pkg::*;

  logic        a_nan, a_snan, b_nan, b_snan;
  logic        a_sign, b_sign;
  logic [30:0] a_mag, b_mag;
  logic        a_lt_b;
  word_t       picked;

  function automatic logic is_nan(word_t val, fp_fmt_e fmt);
    return (fmt == FMT_FP16) ? ((&val[14:10]) && (|val[9:0]))
                             : ((&val[30:23]) && (|val[22:0]));
  endfunction

  // Quiet bit is the MSB of the mantissa
  function automatic logic is_snan(word_t val, fp_fmt_e fmt);
    return is_nan(val, fmt) && !((fmt == FMT_FP16) ? val[9] : val[22]);
  endfunction

  assign a_nan  = is_nan(operand_a_i, fmt_i);
  assign b_nan  = is_nan(operand_b_i, fmt_i);
  assign a_snan = is_snan(operand_a_i, fmt_i);
  assign b_snan = is_snan(operand_b_i, fmt_i);

  // --------------------
  // Sign/magnitude view
  // --------------------
  always_comb begin : split
    if (fmt_i == FMT_FP16) begin
      a_sign = operand_a_i[15];
      b_sign = operand_b_i[15];
      a_mag  = {16'b0, operand_a_i[14:0]};
      b_mag  = {16'b0, operand_b_i[14:0]};
    end else begin
      a_sign = operand_a_i[31];
      b_sign = operand_b_i[31];
      a_mag  = operand_a_i[30:0];
      b_mag  = operand_b_i[30:0];
    end
  end

  always_comb begin : compare
    if (a_sign != b_sign) begin
      a_lt_b = a_sign;           // Also orders -0 below +0
    end else if (a_sign) begin
      a_lt_b = (a_mag > b_mag);  // Both negative
    end else begin
      a_lt_b = (a_mag < b_mag);
    end
  end

  always_comb begin : select
    if (a_nan && b_nan) begin
      picked = (fmt_i == FMT_FP16) ? {16'hFFFF, `FP16_QNAN} : `FP32_QNAN;
    end else if (a_nan) begin
      picked = operand_b_i;
    end else if (b_nan) begin
      picked = operand_a_i;
    end else begin
      picked = (a_lt_b == (op_i == OP_MIN)) ? operand_a_i : operand_b_i;
    end
  end

  assign result_o = (fmt_i == FMT_FP16) ? {16'hFFFF, picked[15:0]} : picked;

  always_comb begin : flags
    status_o            = '0;
    status_o[STATUS_NV] = a_snan | b_snan;  // Any signaling NaN input
  end

endmodule

/* src/slice_issue.sv */
// Input side of the FPU slice
// Checks NaN-boxing of FP16 scalars, slices the operands into lanes
// and gates the lane valids. Purely combinational

`timescale 1ns/1ps
`include "fpu_slice_consts.svh"

module slice_issue (
  input  fpu_slice_pkg::word_t      operand_a_i,
  input  fpu_slice_pkg::word_t      operand_b_i,
  input  fpu_slice_pkg::minmax_op_e op_i,
  input  fpu_slice_pkg::fp_fmt_e    fmt_i,
  input  logic                      vectorial_op_i,
  input  fpu_slice_pkg::lane_mask_t simd_mask_i,
  input  fpu_slice_pkg::tag_t       tag_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  lane_req_if.issue                 lane0_o,
  lane_req_if.issue                 lane1_o
);
  import fpu_slice_pkg::*;

  logic  is_fp16;
  logic  is_vector;
  logic  a_boxed;
  logic  b_boxed;
  half_t a_lo;
  half_t b_lo;
  aux_t  aux;

  assign is_fp16   = (fmt_i == FMT_FP16);
  assign is_vector = is_fp16 & vectorial_op_i;  // FP32 has no vector form here

  // Upper half must be all ones for a legal FP16 scalar
  assign a_boxed = &operand_a_i[31:16];
  assign b_boxed = &operand_b_i[31:16];
  assign a_lo    = (is_vector || a_boxed) ? operand_a_i[15:0] : `FP16_QNAN;
  assign b_lo    = (is_vector || b_boxed) ? operand_b_i[15:0] : `FP16_QNAN;

  assign aux[AUX_FMT] = is_fp16;
  assign aux[AUX_VEC] = is_vector;

  // --------------------
  // Lane 0
  // --------------------
  assign lane0_o.valid     = in_valid_i;
  assign lane0_o.operand_a = is_fp16 ? {16'hFFFF, a_lo} : operand_a_i;
  assign lane0_o.operand_b = is_fp16 ? {16'hFFFF, b_lo} : operand_b_i;
  assign lane0_o.fmt       = fmt_i;
  assign lane0_o.op        = op_i;
  assign lane0_o.mask      = simd_mask_i[0];
  assign lane0_o.tag       = tag_i;
  assign lane0_o.aux       = aux;

  // --------------------
  // Lane 1, upper FP16 half
  // --------------------
  assign lane1_o.valid     = in_valid_i & is_vector;
  assign lane1_o.operand_a = {16'hFFFF, operand_a_i[31:16]};
  assign lane1_o.operand_b = {16'hFFFF, operand_b_i[31:16]};
  assign lane1_o.fmt       = fmt_i;
  assign lane1_o.op        = op_i;
  assign lane1_o.mask      = simd_mask_i[1];
  assign lane1_o.tag       = tag_i;
  assign lane1_o.aux       = aux;

  assign in_ready_o = lane0_o.ready;  // Upstream sees lane 0 only

  // Lane 1 only gets FP16 vectors and has to accept whenever lane 0 does
  lane1_lockstep_a: assert property (@(posedge lane1_o.clk_i)
    lane1_o.valid |-> (lane1_o.fmt == FMT_FP16) && (!lane0_o.ready || lane1_o.ready));

endmodule

/* src/fpu_slice_ifs.sv */
// Lane request and lane response channels of the FPU slice
// One pair per lane, between issue, the lane pipes and packing

`timescale 1ns/1ps

// Issue to lane, valid/ready
interface lane_req_if (input logic clk_i);
  import fpu_slice_pkg::*;

  logic       valid;
  logic       ready;
  word_t      operand_a;
  word_t      operand_b;
  fp_fmt_e    fmt;
  minmax_op_e op;
  logic       mask;   // SIMD mask bit of this lane
  tag_t       tag;
  aux_t       aux;

  modport issue (input clk_i, input ready,
                 output valid, operand_a, operand_b, fmt, op, mask, tag, aux);
  modport lane (input valid, operand_a, operand_b, fmt, op, mask, tag, aux,
                output ready);
endinterface

// Lane to packing, valid/ready
interface lane_rsp_if (input logic clk_i);
  import fpu_slice_pkg::*;

  logic    valid;
  logic    ready;
  word_t   result;
  status_t status;
  logic    mask;
  tag_t    tag;
  aux_t    aux;

  modport lane (output valid, result, status, mask, tag, aux, input ready);
  modport pack (input clk_i, input valid, result, status, mask, tag, aux,
                output ready);
endinterface

/* src/fpu_slice_pkg.sv */
// Shared types of the FPU slice
// Compile before the interfaces and modules that import it

`include "fpu_slice_consts.svh"

package fpu_slice_pkg;

  // --------------------
  // Vector types
  // --------------------
  typedef logic [`SLICE_WIDTH-1:0]   word_t;       // Full slice operand or result
  typedef logic [`SLICE_WIDTH/2-1:0] half_t;       // One FP16 lane value
  typedef logic [`TAG_WIDTH-1:0]     tag_t;
  typedef logic [4:0]                status_t;     // NV DZ OF UF NX
  typedef logic [`NUM_LANES-1:0]     lane_mask_t;  // One bit per lane
  typedef logic [1:0]                aux_t;        // {fmt, vector}

  // Bit positions inside status_t and aux_t
  localparam int unsigned STATUS_NV = 4;
  localparam int unsigned AUX_FMT   = 1;
  localparam int unsigned AUX_VEC   = 0;

  // --------------------
  // Encodings
  // --------------------
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic {
    OP_MIN = 1'b0,
    OP_MAX = 1'b1
  } minmax_op_e;

endpackage

/* src/fpu_slice_consts.svh */
// Global constants of the two-lane min/max FPU slice
// Include wherever a width, the lane count or a NaN pattern is needed

`ifndef FPU_SLICE_CONSTS_SVH
`define FPU_SLICE_CONSTS_SVH

// Datapath geometry
`define SLICE_WIDTH    32
`define NUM_LANES      2
`define TAG_WIDTH      8

// Register stages in every lane
`define NUM_PIPE_REGS  2

// Canonical quiet NaNs
`define FP32_QNAN      32'h7FC0_0000
`define FP16_QNAN      16'h7E00

`endif
